//--- src.f
src/lidar_pkg.sv
src/packet_decoder.sv
src/distance_tracker.sv
src/restoring_divider.sv
src/angle_calculator.sv
src/lidar_scan_top.sv
testbench/lidar_scan_assertions.sv
testbench/tb_lidar_scan.sv

//--- run_sim.sh
#!/bin/sh
# compile and run the lidar scan testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
    --top-module tb_lidar_scan -f src.f -o sim_lidar

# the log decides the result, a failed assertion may also stop the run early
./obj_dir/sim_lidar > sim.log 2>&1 || echo "simulator exited with an error"
cat sim.log

if grep -q "^Simulation completed successfully$" sim.log; then
    echo "run_sim: PASS"
    exit 0
fi
echo "run_sim: FAIL"
exit 1

//--- testbench/tb_lidar_scan.sv
`timescale 1ns/1ns
module tb_lidar_scan;
    import lidar_pkg::*;

    localparam int CLK_PERIOD     = 40;
    localparam int DRIVE_DELAY    = 2;
    localparam int RESET_CYCLES   = 5;
    // smallest spacing between strobes plus a random 0..3 on top
    localparam int BYTE_GAP       = 12;
    localparam int RANDOM_PACKETS = 10;
    localparam int NUM_TESTS      = 5;
    // longer than the 54 cycle result latency so a stray result still shows up
    localparam int SETTLE_CYCLES  = 70;

    logic        clk;
    logic        TxD_reset;
    byte_t       data;
    logic        take_data;
    angle_t      min_angle;
    angle_t      max_angle;
    logic [15:0] obs_alert;
    logic        result_valid;

    integer      seed = 32'h3d01;
    // whole byte stream and the stream position where each test ends
    byte_t       stim[$];
    int          test_end[$];
    // reference results in packet order and tagged with their test
    angle_t      exp_min[$];
    angle_t      exp_max[$];
    logic [15:0] exp_alert[$];
    int          exp_test[$];
    string       test_names[NUM_TESTS] = '{"random_packets", "header_hunt", "short_count",
                                           "wrapped_span", "zero_samples"};
    int          cur_test = 0;
    int          errors = 0;
    int          checked = 0;
    int          test_results = 0;
    int          test_errors_start = 0;
    int          cycle_cnt = 0;
    int          cycle_limit = 1000000;

    lidar_scan_top u_dut (
        .clk          (clk),
        .TxD_reset    (TxD_reset),
        .data         (data),
        .take_data    (take_data),
        .min_angle    (min_angle),
        .max_angle    (max_angle),
        .obs_alert    (obs_alert),
        .result_valid (result_valid)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic int rand_below(input int n);
        int r;
        r = $random(seed) & 32'h7fffffff;
        return r % n;
    endfunction

    // never 0x55 so filler cannot open a header by accident
    function automatic byte_t garbage_byte();
        byte_t b;
        b = byte_t'(rand_below(256));
        if (b == HEADER_FIRST) begin
            b = 8'h00;
        end
        return b;
    endfunction

    // about one in eight zero and the rest split around the obstacle threshold
    function automatic dist_t random_distance();
        if (rand_below(8) == 0) begin
            return '0;
        end
        if (rand_below(2) == 0) begin
            return dist_t'(1 + rand_below(127));
        end
        return dist_t'(128 + rand_below(65408));
    endfunction

    task automatic add_garbage(input int n);
        for (int i = 0; i < n; i++) begin
            stim.push_back(garbage_byte());
        end
    endtask

    // header and a rejected count only
    task automatic add_short_packet(input int count);
        stim.push_back(HEADER_FIRST);
        stim.push_back(HEADER_SECOND);
        stim.push_back(byte_t'(count));
    endtask

    // full packet plus its reference result
    task automatic add_packet(input int count, input angle_t start_a, input angle_t end_a,
                              input bit all_zero, input int test_idx);
        dist_t       d;
        dist_t       min_d;
        dist_t       max_d;
        int          min_i;
        int          max_i;
        logic [15:0] alert;
        angle_t      span;
        int          sum;
        stim.push_back(HEADER_FIRST);
        stim.push_back(HEADER_SECOND);
        stim.push_back(byte_t'(count));
        stim.push_back(start_a[7:0]);
        stim.push_back(start_a[15:8]);
        stim.push_back(end_a[7:0]);
        stim.push_back(end_a[15:8]);
        min_d = 16'hFFFF;
        max_d = '0;
        min_i = 0;
        max_i = 0;
        alert = '0;
        for (int i = 0; i < count; i++) begin
            d = all_zero ? '0 : random_distance();
            stim.push_back(d[7:0]);
            stim.push_back(d[15:8]);
            // zero is no echo and only uses up an index
            if (d != '0) begin
                // first strict extreme wins on ties
                if (d < min_d) begin
                    min_d = d;
                    min_i = i;
                end
                if (d > max_d) begin
                    max_d = d;
                    max_i = i;
                end
                if (i < ALERT_SAMPLES) begin
                    alert = {d < OBS_DISTANCE, alert[15:1]};
                end
            end
        end
        // modulo 2^16 span and truncated division by count - 1
        span = end_a - start_a;
        sum = int'(start_a) + (min_i * int'(span)) / (count - 1);
        exp_min.push_back(sum[15:0]);
        sum = int'(start_a) + (max_i * int'(span)) / (count - 1);
        exp_max.push_back(sum[15:0]);
        exp_alert.push_back(alert);
        exp_test.push_back(test_idx);
    endtask

    task automatic build_stimulus();
        for (int p = 0; p < RANDOM_PACKETS; p++) begin
            // two or more filler bytes hold the next scan_start until the last result is out
            add_garbage(2 + rand_below(3));
            add_packet(2 + rand_below(39), angle_t'(rand_below(65536)),
                       angle_t'(rand_below(65536)), 1'b0, 0);
        end
        test_end.push_back(stim.size());
        // lone 0x55 with a wrong byte and a run of 0x55 ended by junk
        add_garbage(5);
        stim.push_back(HEADER_FIRST);
        stim.push_back(8'h3C);
        repeat (3) stim.push_back(HEADER_FIRST);
        stim.push_back(8'h00);
        add_garbage(2);
        add_packet(8, 16'h1000, 16'h2000, 1'b0, 1);
        test_end.push_back(stim.size());
        add_short_packet(0);
        add_garbage(3);
        add_short_packet(1);
        add_garbage(3);
        test_end.push_back(stim.size());
        // start in the upper quarter and end below it
        for (int p = 0; p < 3; p++) begin
            add_garbage(2 + rand_below(3));
            add_packet(2 + rand_below(39), angle_t'(16'hC000 + rand_below(16'h4000)),
                       angle_t'(rand_below(16'h4000)), 1'b0, 3);
        end
        test_end.push_back(stim.size());
        add_packet(5, 16'h0200, 16'h0900, 1'b1, 4);
        add_garbage(2 + rand_below(3));
        add_packet(2 + rand_below(39), angle_t'(rand_below(65536)),
                   angle_t'(rand_below(65536)), 1'b1, 4);
        test_end.push_back(stim.size());
    endtask

    task automatic send_byte(input byte_t b);
        @(posedge clk);
        #DRIVE_DELAY;
        data      = b;
        take_data = 1'b1;
        @(posedge clk);
        #DRIVE_DELAY;
        take_data = 1'b0;
        repeat (BYTE_GAP - 2 + rand_below(4)) @(posedge clk);
    endtask

    // waits for this test's results and gives a stray result time to appear
    task automatic finish_test();
        while (exp_test.size() != 0 && exp_test[0] <= cur_test) begin
            @(posedge clk);
        end
        repeat (SETTLE_CYCLES) @(posedge clk);
        $display("test %s: %0d results, %0d errors", test_names[cur_test], test_results,
                 errors - test_errors_start);
        test_results      = 0;
        test_errors_start = errors;
        cur_test          = cur_test + 1;
    endtask

    task automatic check_field(input string field, input logic [15:0] expected,
                               input logic [15:0] actual);
        assert (actual == expected) else begin
            $display("MISMATCH %s %s expected %04h actual %04h", test_names[cur_test], field,
                     expected, actual);
            errors++;
        end
    endtask

    // outputs settle after the rising edge and are read half a period later
    always @(negedge clk) begin
        if (!TxD_reset && result_valid) begin
            assert (exp_test.size() != 0 && exp_test[0] == cur_test) else begin
                $display("%s: result_valid arrived with no packet pending", test_names[cur_test]);
                errors++;
            end
            if (exp_test.size() != 0 && exp_test[0] == cur_test) begin
                check_field("min_angle", exp_min[0], min_angle);
                check_field("max_angle", exp_max[0], max_angle);
                check_field("obs_alert", exp_alert[0], obs_alert);
                void'(exp_min.pop_front());
                void'(exp_max.pop_front());
                void'(exp_alert.pop_front());
                void'(exp_test.pop_front());
                checked++;
                test_results++;
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit) begin
            $display("timeout after %0d cycles, an expected result never arrived", cycle_cnt);
            $display("Simulation failed");
            $finish;
        end
    end

    initial begin
        TxD_reset = 1'b1;
        data      = '0;
        take_data = 1'b0;
        build_stimulus();
        // up to 16 cycles per byte plus the settle window of every test
        cycle_limit = stim.size() * 16 + NUM_TESTS * (SETTLE_CYCLES + 60) + 200;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        TxD_reset = 1'b0;
        for (int i = 0; i < stim.size(); i++) begin
            send_byte(stim[i]);
            if (cur_test < NUM_TESTS && i + 1 == test_end[cur_test]) begin
                finish_test();
            end
        end
        $display("tests %0d, results checked %0d, errors %0d", NUM_TESTS, checked, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- testbench/lidar_scan_assertions.sv
`timescale 1ns/1ns
module lidar_scan_assertions (
    input logic clk,
    input logic TxD_reset,
    input logic scan_done,
    input logic result_valid,
    input logic div_start,
    input logic div_busy
);

    // cycles since a scan_done that still waits for its result
    logic [6:0] wait_cnt;
    logic       waiting;

    always_ff @(posedge clk) begin
        if (TxD_reset || result_valid) begin
            waiting  <= 1'b0;
            wait_cnt <= '0;
        end else if (scan_done && !waiting) begin
            waiting  <= 1'b1;
            wait_cnt <= 7'd1;
        end else if (waiting && wait_cnt != '1) begin
            // saturates so a lost result keeps failing
            wait_cnt <= wait_cnt + 1'b1;
        end
    end

    single_cycle_valid: assert property (@(posedge clk) disable iff (TxD_reset)
        result_valid |=> !result_valid)
        else $error("result_valid held for two cycles");

    result_latency: assert property (@(posedge clk) disable iff (TxD_reset)
        waiting |-> wait_cnt <= 7'd60)
        else $error("no result_valid within 60 cycles of scan_done");

    // a second start would restart a division in flight
    no_start_while_busy: assert property (@(posedge clk) disable iff (TxD_reset)
        div_start |-> !div_busy)
        else $error("div_start while the divider is running");

endmodule

bind lidar_scan_top lidar_scan_assertions u_assertions (
    .clk          (clk),
    .TxD_reset    (TxD_reset),
    .scan_done    (scan_done),
    .result_valid (result_valid),
    .div_start    (u_angle.div_start),
    .div_busy     (u_angle.u_divider.busy)
);

//--- src/lidar_scan_top.sv
`timescale 1ns/1ns
module lidar_scan_top (
    input  logic              clk,
    input  logic              TxD_reset,
    input  lidar_pkg::byte_t  data,
    input  logic              take_data,
    output lidar_pkg::angle_t min_angle,
    output lidar_pkg::angle_t max_angle,
    output logic [15:0]       obs_alert,
    output logic              result_valid
);
    import lidar_pkg::*;

    // decoder to tracker
    logic   scan_start;
    logic   sample_valid;
    dist_t  sample_dist;
    count_t sample_idx;

    // decoder to angle calculator
    logic   scan_done;
    angle_t start_angle;
    angle_t end_angle;
    count_t sample_count;

    // tracker to angle calculator
    count_t min_idx;
    count_t max_idx;

    packet_decoder u_decoder (
        .clk          (clk),
        .TxD_reset    (TxD_reset),
        .data         (data),
        .take_data    (take_data),
        .scan_start   (scan_start),
        .sample_valid (sample_valid),
        .sample_dist  (sample_dist),
        .sample_idx   (sample_idx),
        .scan_done    (scan_done),
        .start_angle  (start_angle),
        .end_angle    (end_angle),
        .sample_count (sample_count)
    );

    distance_tracker u_tracker (
        .clk          (clk),
        .TxD_reset    (TxD_reset),
        .scan_start   (scan_start),
        .sample_valid (sample_valid),
        .sample_dist  (sample_dist),
        .sample_idx   (sample_idx),
        .min_idx      (min_idx),
        .max_idx      (max_idx),
        .obs_alert    (obs_alert)
    );

    angle_calculator u_angle (
        .clk          (clk),
        .TxD_reset    (TxD_reset),
        .scan_done    (scan_done),
        .start_angle  (start_angle),
        .end_angle    (end_angle),
        .sample_count (sample_count),
        .min_idx      (min_idx),
        .max_idx      (max_idx),
        .min_angle    (min_angle),
        .max_angle    (max_angle),
        .result_valid (result_valid)
    );

endmodule

//--- src/angle_calculator.sv
`timescale 1ns/1ns
module angle_calculator (
    input  logic              clk,
    input  logic              TxD_reset,
    input  logic              scan_done,
    input  lidar_pkg::angle_t start_angle,
    input  lidar_pkg::angle_t end_angle,
    input  lidar_pkg::count_t sample_count,
    input  lidar_pkg::count_t min_idx,
    input  lidar_pkg::count_t max_idx,
    output lidar_pkg::angle_t min_angle,
    output lidar_pkg::angle_t max_angle,
    output logic              result_valid
);
    import lidar_pkg::*;

    calc_state_t state;

    // scan values captured at scan_done, the decoder may move on meanwhile
    angle_t      base_angle;
    angle_t      span;
    count_t      max_idx_r;
    count_t      divisor;
    dividend_t   dividend;
    // nearest angle waits here until the farthest one is ready
    angle_t      min_sum;
    angle_t      max_sum;

    logic        div_start;
    dividend_t   quotient;
    logic        div_done;
    angle_t      span_now;

    // span wraps naturally when the end angle is below the start angle
    assign span_now = end_angle - start_angle;

    restoring_divider u_divider (
        .clk       (clk),
        .TxD_reset (TxD_reset),
        .div_start (div_start),
        .dividend  (dividend),
        .divisor   (divisor),
        .quotient  (quotient),
        .div_done  (div_done)
    );

    always_ff @(posedge clk) begin
        if (TxD_reset) begin
            state        <= idle;
            div_start    <= 1'b0;
            result_valid <= 1'b0;
            min_angle    <= '0;
            max_angle    <= '0;
        end else begin
            div_start    <= 1'b0;
            result_valid <= 1'b0;
            case (state)
                // scan_done outside idle is dropped
                idle: begin
                    if (scan_done) begin
                        div_start <= 1'b1;
                        state     <= divide_min;
                    end
                end
                divide_min: begin
                    if (div_done) begin
                        div_start <= 1'b1;
                        state     <= divide_max;
                    end
                end
                divide_max: begin
                    if (div_done) begin
                        state <= finish;
                    end
                end
                finish: begin
                    // both angles change together with the valid pulse
                    min_angle    <= min_sum;
                    max_angle    <= max_sum;
                    result_valid <= 1'b1;
                    state        <= idle;
                end
                default: state <= idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == idle && scan_done) begin
            base_angle <= start_angle;
            span       <= span_now;
            max_idx_r  <= max_idx;
            divisor    <= count_t'(sample_count - 1'b1);
            dividend   <= dividend_t'(min_idx) * dividend_t'(span_now);
        end else if (state == divide_min && div_done) begin
            // quotient never exceeds the span, low 16 bits are enough
            min_sum  <= base_angle + quotient[ANGLE_W-1:0];
            dividend <= dividend_t'(max_idx_r) * dividend_t'(span);
        end else if (state == divide_max && div_done) begin
            max_sum <= base_angle + quotient[ANGLE_W-1:0];
        end
    end

endmodule

//--- src/restoring_divider.sv
`timescale 1ns/1ns
module restoring_divider (
    input  logic                 clk,
    input  logic                 TxD_reset,
    input  logic                 div_start,
    input  lidar_pkg::dividend_t dividend,
    input  lidar_pkg::count_t    divisor,
    output lidar_pkg::dividend_t quotient,
    output logic                 div_done
);
    import lidar_pkg::*;

    localparam int STEP_W = $clog2(DIV_STEPS + 1);
    localparam int REM_W  = COUNT_W + 1;

    // partial remainder, one bit wider than the divisor so the shifted value fits
    logic [REM_W-1:0]  remainder;
    // dividend bits shift out of the top while quotient bits fill in from the bottom
    dividend_t         work;
    logic [STEP_W-1:0] steps_left;
    logic              busy;

    logic [REM_W-1:0]  shifted;
    logic [REM_W:0]    diff;
    logic              fits;

    // next remainder candidate pulls in the top dividend bit
    assign shifted  = {remainder[REM_W-2:0], work[DIVIDEND_W-1]};
    assign diff     = {1'b0, shifted} - {2'b00, divisor};
    // no borrow means the divisor goes into the remainder
    assign fits     = ~diff[REM_W];
    assign quotient = work;

    always_ff @(posedge clk) begin
        if (TxD_reset) begin
            busy       <= 1'b0;
            div_done   <= 1'b0;
            steps_left <= '0;
        end else begin
            div_done <= 1'b0;
            if (div_start) begin
                busy       <= 1'b1;
                steps_left <= STEP_W'(DIV_STEPS);
            end else if (busy) begin
                steps_left <= steps_left - 1'b1;
                // done lands with the final quotient bit
                if (steps_left == STEP_W'(1)) begin
                    busy     <= 1'b0;
                    div_done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (div_start) begin
            remainder <= '0;
            work      <= dividend;
        end else if (busy) begin
            remainder <= fits ? diff[REM_W-1:0] : shifted;
            work      <= {work[DIVIDEND_W-2:0], fits};
        end
    end

endmodule

//--- src/distance_tracker.sv
`timescale 1ns/1ns
module distance_tracker (
    input  logic              clk,
    input  logic              TxD_reset,
    input  logic              scan_start,
    input  logic              sample_valid,
    input  lidar_pkg::dist_t  sample_dist,
    input  lidar_pkg::count_t sample_idx,
    output lidar_pkg::count_t min_idx,
    output lidar_pkg::count_t max_idx,
    output logic [15:0]       obs_alert
);
    import lidar_pkg::*;

    // running extremes of the current scan
    dist_t min_dist;
    dist_t max_dist;

    // zero distance means no echo, the sample is skipped
    logic  sample_nonzero;
    logic  closer;
    logic  farther;
    logic  in_alert_window;
    logic  obstacle;

    assign sample_nonzero  = (sample_dist != '0);
    // strict compares keep the first index on ties
    assign closer          = (sample_dist < min_dist);
    assign farther         = (sample_dist > max_dist);
    assign in_alert_window = (sample_idx < count_t'(ALERT_SAMPLES));
    assign obstacle        = (sample_dist < OBS_DISTANCE);

    always_ff @(posedge clk) begin
        if (TxD_reset || scan_start) begin
            // start of scan looks the same as reset
            min_dist  <= '1;
            max_dist  <= '0;
            min_idx   <= '0;
            max_idx   <= '0;
            obs_alert <= '0;
        end else if (sample_valid && sample_nonzero) begin
            if (closer) begin
                min_dist <= sample_dist;
                min_idx  <= sample_idx;
            end
            if (farther) begin
                max_dist <= sample_dist;
                max_idx  <= sample_idx;
            end
            // newest sample enters at bit 15, oldest drops out at bit 0
            if (in_alert_window) begin
                obs_alert <= {obstacle, obs_alert[15:1]};
            end
        end
    end

endmodule

//--- src/packet_decoder.sv
`timescale 1ns/1ns
module packet_decoder (
    input  logic              clk,
    input  logic              TxD_reset,
    input  lidar_pkg::byte_t  data,
    input  logic              take_data,
    output logic              scan_start,
    output logic              sample_valid,
    output lidar_pkg::dist_t  sample_dist,
    output lidar_pkg::count_t sample_idx,
    output logic              scan_done,
    output lidar_pkg::angle_t start_angle,
    output lidar_pkg::angle_t end_angle,
    output lidar_pkg::count_t sample_count
);
    import lidar_pkg::*;

    decode_state_t state;
    // low half of the field being assembled
    byte_t         low_byte;
    // index of the next sample to arrive
    count_t        sample_cnt;
    // set on the final sample strobe, turns into scan_done next cycle
    logic          last_sample;

    // control path, state and strobes
    always_ff @(posedge clk) begin
        if (TxD_reset) begin
            state        <= hunt_first;
            sample_cnt   <= '0;
            last_sample  <= 1'b0;
            scan_start   <= 1'b0;
            sample_valid <= 1'b0;
            scan_done    <= 1'b0;
        end else begin
            // strobes last one cycle unless set again below
            scan_start   <= 1'b0;
            sample_valid <= 1'b0;
            scan_done    <= last_sample;
            last_sample  <= 1'b0;
            if (take_data) begin
                case (state)
                    hunt_first: begin
                        if (data == HEADER_FIRST) begin
                            state <= hunt_second;
                        end
                    end
                    hunt_second: begin
                        // another 0x55 may still be the real first header byte
                        if (data == HEADER_SECOND) begin
                            state <= read_count;
                        end else if (data != HEADER_FIRST) begin
                            state <= hunt_first;
                        end
                    end
                    read_count: begin
                        if (data < byte_t'(MIN_SAMPLES)) begin
                            state <= hunt_first;
                        end else begin
                            scan_start <= 1'b1;
                            sample_cnt <= '0;
                            state      <= read_start_lo;
                        end
                    end
                    read_start_lo:  state <= read_start_hi;
                    read_start_hi:  state <= read_end_lo;
                    read_end_lo:    state <= read_end_hi;
                    read_end_hi:    state <= read_sample_lo;
                    read_sample_lo: state <= read_sample_hi;
                    read_sample_hi: begin
                        sample_valid <= 1'b1;
                        sample_cnt   <= sample_cnt + 1'b1;
                        // last sample ends the packet, go back to sync search
                        if (sample_cnt == count_t'(sample_count - 1'b1)) begin
                            last_sample <= 1'b1;
                            state       <= hunt_first;
                        end else begin
                            state <= read_sample_lo;
                        end
                    end
                    default: state <= hunt_first;
                endcase
            end
        end
    end

    // payload path, fields are little endian
    always_ff @(posedge clk) begin
        if (take_data) begin
            case (state)
                read_count: begin
                    // a rejected count must not disturb the previous packet
                    if (data >= byte_t'(MIN_SAMPLES)) begin
                        sample_count <= data;
                    end
                end
                read_start_lo, read_end_lo, read_sample_lo: low_byte <= data;
                read_start_hi: start_angle <= {data, low_byte};
                read_end_hi:   end_angle   <= {data, low_byte};
                read_sample_hi: begin
                    sample_dist <= {data, low_byte};
                    sample_idx  <= sample_cnt;
                end
                default: low_byte <= low_byte;
            endcase
        end
    end

endmodule

//--- src/lidar_pkg.sv
package lidar_pkg;

    // field widths of the sensor stream
    localparam int BYTE_W     = 8;
    localparam int DIST_W     = 16;
    localparam int ANGLE_W    = 16;
    localparam int COUNT_W    = 8;
    // index times span, 8 by 16 bits
    localparam int DIVIDEND_W = COUNT_W + ANGLE_W;

    typedef logic [BYTE_W-1:0]     byte_t;
    typedef logic [DIST_W-1:0]     dist_t;
    typedef logic [ANGLE_W-1:0]    angle_t;
    typedef logic [COUNT_W-1:0]    count_t;
    typedef logic [DIVIDEND_W-1:0] dividend_t;

    // one quotient bit per dividend bit
    localparam int DIV_STEPS = DIVIDEND_W;

    // packet sync pattern
    localparam byte_t HEADER_FIRST  = 8'h55;
    localparam byte_t HEADER_SECOND = 8'hAA;

    // samples closer than this raise an alert bit
    localparam dist_t OBS_DISTANCE  = 16'h0080;
    // only the leading sample positions feed the alert register
    localparam int    ALERT_SAMPLES = 16;
    // fewer than two samples would give a zero divisor
    localparam int    MIN_SAMPLES   = 2;

    typedef enum logic [3:0] {
        hunt_first,
        hunt_second,
        read_count,
        read_start_lo,
        read_start_hi,
        read_end_lo,
        read_end_hi,
        read_sample_lo,
        read_sample_hi
    } decode_state_t;

    typedef enum logic [1:0] {
        idle,
        divide_min,
        divide_max,
        finish
    } calc_state_t;

endpackage
